/* src.f */
verilog/fetch_pkg.sv
verilog/prefetch.sv
verilog/byte_fifo.sv
verilog/immediate_reader.sv
verilog/fetch_unit.sv
test/tb_clock.sv
test/fetch_unit_assertions.sv
test/fetch_unit_tb.sv

/* test/fetch_unit_assertions.sv */
// Bus and strobe checks for the fetch front end, bound into fetch_unit
// Instruction bus hold rules, FIFO overflow and single-cycle completion
module fetch_unit_assertions (
    input logic                 clk,
    input logic                 arst_n,
    input fetch_pkg::imem_req_t instr_req,
    input fetch_pkg::imem_rsp_t instr_rsp,
    input logic                 fifo_wr_en,
    input logic                 fifo_full,
    input logic                 immed_complete
);
    timeunit 1ns;
    timeprecision 1ps;

    // Failed checks so far, watched by the testbench
    int unsigned fail_count = 0;

    // Request holds until its ack
    req_held_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        instr_req.access && !instr_rsp.ack |=> instr_req.access && $stable(instr_req.address)
    ) else begin
        fail_count++;
        $error("instr_req access or address changed before ack");
    end

    // Access drops in the cycle after the ack
    req_drop_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        instr_req.access && instr_rsp.ack |=> !instr_req.access
    ) else begin
        fail_count++;
        $error("instr_req access still high after ack");
    end

    no_overflow_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        fifo_wr_en |-> !fifo_full
    ) else begin
        fail_count++;
        $error("byte FIFO written while full");
    end

    // Completion is a single-cycle pulse
    complete_pulse_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        immed_complete |=> !immed_complete
    ) else begin
        fail_count++;
        $error("immed_complete high for two cycles");
    end

endmodule

bind fetch_unit fetch_unit_assertions fetch_unit_assertions_i (
    .clk            (clk),
    .arst_n         (arst_n),
    .instr_req      (instr_req),
    .instr_rsp      (instr_rsp),
    .fifo_wr_en     (fifo_wr_en),
    .fifo_full      (byte_fifo_i.full),
    .immed_complete (immed_complete)
);

/* test/fetch_unit_tb.sv */
// Testbench for the instruction fetch front end
// Word memory model with random ack delays, a table of redirects and
// immediate reads, expected values taken from the memory byte rule
module fetch_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import fetch_pkg::*;

    typedef enum logic [1:0] {
        row_stay,     // keep the current CS:IP
        row_redirect,
        row_busy      // redirect over an outstanding fetch and a waiting read
    } row_mode_t;

    typedef struct packed {
        row_mode_t   mode;
        addr16_t     cs;
        addr16_t     ip;
        logic [7:0]  count;
        logic [15:0] wide_mask;   // bit i set makes read i 16-bit
    } stim_row_t;

    localparam int num_rows  = 6;
    localparam int delay_len = 64;

    localparam stim_row_t stim_table [num_rows] = '{
        '{row_stay,     reset_cs, reset_ip, 8'd6,  16'h0000},
        '{row_redirect, 16'h1234, 16'h0010, 8'd5,  16'h001f},
        '{row_redirect, 16'h0800, 16'h0031, 8'd5,  16'h0015},
        '{row_busy,     16'h2000, 16'h0100, 8'd4,  16'h000f},
        '{row_redirect, 16'h0100, 16'h0007, 8'd10, 16'h0256},
        '{row_busy,     16'h0abc, 16'h0333, 8'd3,  16'h0005}
    };

    // Odd address whose bytes must never reach a checked immediate
    localparam addr16_t decoy_cs = 16'h3000;
    localparam addr16_t decoy_ip = 16'h0077;

    logic        clk;
    logic        arst_n;
    addr16_t     new_cs;
    addr16_t     new_ip;
    logic        load_new_ip;
    imem_req_t   instr_req;
    imem_rsp_t   instr_rsp = '0;
    logic        immed_start;
    logic        immed_is_8bit;
    logic        immed_complete;
    word_t       immediate;

    int unsigned delay_tab [delay_len];
    int unsigned delay_idx = 0;
    int unsigned mem_wait = 0;
    logic        mem_busy = 1'b0;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    int          complete_count = 0;
    int          reads_done = 0;

    tb_clock #(
        .period_ns (40)
    ) tb_clock_i (
        .clk (clk)
    );

    fetch_unit #(
        .fifo_depth (6)
    ) fetch_unit_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .new_cs         (new_cs),
        .new_ip         (new_ip),
        .load_new_ip    (load_new_ip),
        .instr_req      (instr_req),
        .instr_rsp      (instr_rsp),
        .immed_start    (immed_start),
        .immed_is_8bit  (immed_is_8bit),
        .immed_complete (immed_complete),
        .immediate      (immediate)
    );

    // Memory contents, defined for every physical address
    function automatic byte_t mem_byte(input logic [19:0] phys);
        return phys[7:0] ^ phys[15:8];
    endfunction

    function automatic word_t mem_word(input word_addr_t addr);
        return {mem_byte({addr, 1'b1}), mem_byte({addr, 1'b0})};
    endfunction

    // Segment times 16 plus offset, wrapping at 1 MB
    function automatic logic [19:0] seg_to_phys(input addr16_t cs, input addr16_t ip);
        int unsigned linear;
        linear = int'(cs) * 16 + int'(ip);
        return linear[19:0];
    endfunction

    function automatic int run_cycle_limit();
        int reads;
        reads = 0;
        for (int r = 0; r < num_rows; r++) begin
            reads += int'(stim_table[r].count);
            // Aborted decoy read
            if (stim_table[r].mode == row_busy) begin
                reads += 1;
            end
        end
        return reads * 20 + 200;
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("mismatch %s: got %h, expected %h",
                                        name, actual, expected));
        end
    endtask

    // Memory model, acks each request after 0 to 3 extra cycles
    always @(posedge clk) begin
        if (!arst_n) begin
            instr_rsp <= '0;
            mem_busy = 1'b0;
        end else if (instr_rsp.ack) begin
            instr_rsp.ack <= 1'b0;
        end else if (instr_req.access) begin
            if (!mem_busy) begin
                mem_wait  = delay_tab[delay_idx];
                delay_idx = (delay_idx + 1) % delay_len;
                mem_busy  = 1'b1;
            end
            if (mem_wait == 0) begin
                instr_rsp.ack  <= 1'b1;
                instr_rsp.data <= mem_word(instr_req.address);
                mem_busy = 1'b0;
            end else begin
                mem_wait = mem_wait - 1;
            end
        end
    end

    always @(posedge clk) begin
        if (immed_complete) begin
            complete_count <= complete_count + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            stop_with_failure($sformatf("timeout: run did not finish within %0d cycles",
                                        cycle_limit));
        end else if (fetch_unit_i.fetch_unit_assertions_i.fail_count != 0) begin
            stop_with_failure("bound assertion failed, see the error above");
        end
    end

    // Caller is just past a rising edge
    task automatic redirect(input addr16_t cs, input addr16_t ip);
        new_cs      <= cs;
        new_ip      <= ip;
        load_new_ip <= 1'b1;
        @(posedge clk);
        load_new_ip <= 1'b0;
    endtask

    task automatic read_immediate(input logic wide, inout logic [19:0] byte_ptr);
        word_t expected;
        if (wide) begin
            expected = {mem_byte(byte_ptr + 20'd1), mem_byte(byte_ptr)};
            byte_ptr = byte_ptr + 20'd2;
        end else begin
            expected = {8'h00, mem_byte(byte_ptr)};
            byte_ptr = byte_ptr + 20'd1;
        end
        @(posedge clk);
        // One completion per finished read, none from aborted ones
        check_value("immed_complete count", complete_count, reads_done);
        immed_start   <= 1'b1;
        immed_is_8bit <= !wide;
        @(posedge clk);
        immed_start <= 1'b0;
        while (immed_complete !== 1'b1) begin
            @(posedge clk);
        end
        check_value("immediate", immediate, expected);
        reads_done++;
    endtask

    task automatic abort_and_redirect(input addr16_t cs, input addr16_t ip);
        logic [19:0] decoy_phys;
        word_addr_t  decoy_word;
        decoy_phys = seg_to_phys(decoy_cs, decoy_ip);
        decoy_word = decoy_phys[19:1];
        @(posedge clk);
        redirect(decoy_cs, decoy_ip);
        // 16-bit read that gets only one byte from the odd decoy word
        immed_start   <= 1'b1;
        immed_is_8bit <= 1'b0;
        @(posedge clk);
        immed_start <= 1'b0;
        while (!(instr_rsp.ack && instr_req.address == decoy_word)) begin
            @(posedge clk);
        end
        @(posedge clk);
        while (!instr_req.access) begin
            @(posedge clk);
        end
        // Next word in flight, read still waiting for its high byte
        redirect(cs, ip);
    endtask

    task automatic run_row(input stim_row_t row);
        logic [19:0] byte_ptr;
        byte_ptr = seg_to_phys(row.cs, row.ip);
        if (row.mode == row_busy) begin
            abort_and_redirect(row.cs, row.ip);
        end else if (row.mode == row_redirect) begin
            @(posedge clk);
            redirect(row.cs, row.ip);
        end
        for (int i = 0; i < int'(row.count); i++) begin
            read_immediate(row.wide_mask[i], byte_ptr);
        end
    endtask

    initial begin
        logic [19:0] reset_phys;
        arst_n        = 1'b0;
        new_cs        = '0;
        new_ip        = '0;
        load_new_ip   = 1'b0;
        immed_start   = 1'b0;
        immed_is_8bit = 1'b0;
        void'($urandom(32'hd6307b23));
        for (int i = 0; i < delay_len; i++) begin
            delay_tab[i] = $urandom % 4;
        end
        cycle_limit = run_cycle_limit();

        // Two rising edges in reset
        @(posedge clk);
        @(posedge clk);
        check_value("instr_req.access", instr_req.access, 1'b0);
        arst_n <= 1'b1;

        // First access goes to the reset vector
        do begin
            @(posedge clk);
        end while (!instr_req.access);
        reset_phys = seg_to_phys(reset_cs, reset_ip);
        check_value("instr_req.address", instr_req.address, reset_phys[19:1]);

        for (int r = 0; r < num_rows; r++) begin
            run_row(stim_table[r]);
        end

        repeat (4) @(posedge clk);
        check_value("immed_complete count", complete_count, reads_done);
        if (fetch_unit_i.fetch_unit_assertions_i.fail_count == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            stop_with_failure("bound assertion failed, see the error above");
        end
    end

endmodule

/* test/tb_clock.sv */
// Testbench clock source
// Free-running clock that starts low, 40 ns period by default
module tb_clock #(
    parameter int period_ns = 40
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
    end

    always begin
        #(period_ns / 2);
        clk = ~clk;
    end

endmodule

/* verilog/byte_fifo.sv */
// Byte-wide first-word-fall-through FIFO
// Head byte is visible whenever not empty; flush drops all contents.
// Nearly full flags two or fewer free entries.
module byte_fifo #(
    parameter int fifo_depth = 6
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             flush,
    input  logic             wr_en,
    input  fetch_pkg::byte_t wr_data,
    input  logic             rd_en,
    output fetch_pkg::byte_t rd_data,
    output logic             empty,
    output logic             nearly_full
);
    import fetch_pkg::*;

    localparam int ptr_width   = $clog2(fifo_depth);
    localparam int count_width = $clog2(fifo_depth + 1);

    byte_t                  mem [fifo_depth];
    logic [ptr_width-1:0]   rd_ptr;
    logic [ptr_width-1:0]   wr_ptr;
    logic [count_width-1:0] count;
    logic                   full;
    logic                   do_wr;
    logic                   do_rd;

    function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
        if (ptr == ptr_width'(fifo_depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full        = count == count_width'(fifo_depth);
    assign empty       = count == '0;
    assign nearly_full = count >= count_width'(fifo_depth - 2);

    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Simultaneous push and pop leaves the count alone
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

/* verilog/fetch_pkg.sv */
// Instruction fetch front end shared definitions
// Bus widths and structs, reset vector and FSM state encodings
package fetch_pkg;

    // One instruction byte and one bus data word
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word_t;

    // Segment or offset value (CS, IP)
    typedef logic [15:0] addr16_t;

    // Physical address bits 19:1, one 16-bit word per address
    typedef logic [18:0] word_addr_t;

    // Instruction bus request, held steady until ack
    typedef struct packed {
        logic       access;
        word_addr_t address;
    } imem_req_t;

    // Instruction bus response, data valid with the ack pulse
    typedef struct packed {
        logic  ack;
        word_t data;
    } imem_rsp_t;

    // Reset vector FFFF:0000, physical FFFF0
    localparam addr16_t reset_cs = 16'hffff;
    localparam addr16_t reset_ip = 16'h0000;

    // Prefetch FSM
    typedef enum logic [1:0] {
        pf_idle,
        pf_fetch,
        pf_high_byte,
        pf_discard
    } prefetch_state_t;

    // Immediate reader FSM
    typedef enum logic {
        rd_idle,
        rd_reading
    } reader_state_t;

endpackage

/* verilog/fetch_unit.sv */
// Instruction fetch front end top level
// Prefetch unit feeds the byte FIFO, the immediate reader drains it.
// The redirect flush from prefetch goes to both other blocks.
module fetch_unit #(
    parameter int fifo_depth = 6
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  fetch_pkg::addr16_t   new_cs,
    input  fetch_pkg::addr16_t   new_ip,
    input  logic                 load_new_ip,
    output fetch_pkg::imem_req_t instr_req,
    input  fetch_pkg::imem_rsp_t instr_rsp,
    input  logic                 immed_start,
    input  logic                 immed_is_8bit,
    output logic                 immed_complete,
    output fetch_pkg::word_t     immediate
);
    import fetch_pkg::*;

    logic  flush;
    logic  fifo_wr_en;
    byte_t fifo_wr_data;
    logic  fifo_nearly_full;
    logic  fifo_rd_en;
    byte_t fifo_rd_data;
    logic  fifo_empty;

    prefetch prefetch_i (
        .clk              (clk),
        .arst_n           (arst_n),
        .new_cs           (new_cs),
        .new_ip           (new_ip),
        .load_new_ip      (load_new_ip),
        .instr_req        (instr_req),
        .instr_rsp        (instr_rsp),
        .fifo_wr_en       (fifo_wr_en),
        .fifo_wr_data     (fifo_wr_data),
        .fifo_nearly_full (fifo_nearly_full),
        .flush            (flush)
    );

    byte_fifo #(
        .fifo_depth (fifo_depth)
    ) byte_fifo_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .flush       (flush),
        .wr_en       (fifo_wr_en),
        .wr_data     (fifo_wr_data),
        .rd_en       (fifo_rd_en),
        .rd_data     (fifo_rd_data),
        .empty       (fifo_empty),
        .nearly_full (fifo_nearly_full)
    );

    immediate_reader immediate_reader_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .flush        (flush),
        .start        (immed_start),
        .is_8bit      (immed_is_8bit),
        .complete     (immed_complete),
        .immediate    (immediate),
        .fifo_rd_en   (fifo_rd_en),
        .fifo_rd_data (fifo_rd_data),
        .fifo_empty   (fifo_empty)
    );

endmodule

/* verilog/immediate_reader.sv */
// Immediate reader
// Pops one or two bytes from the prefetch FIFO and assembles a
// little-endian immediate, zero-extended for 8-bit reads.
// Complete pulses in the cycle after the last pop.
module immediate_reader (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             flush,
    input  logic             start,
    input  logic             is_8bit,
    output logic             complete,
    output fetch_pkg::word_t immediate,
    output logic             fifo_rd_en,
    input  fetch_pkg::byte_t fifo_rd_data,
    input  logic             fifo_empty
);
    import fetch_pkg::*;

    reader_state_t state;
    logic [1:0]    bytes_left;
    logic          wide;
    logic          accept;
    logic          last_pop;

    // Start is ignored while busy and during a flush
    assign accept = (state == rd_idle) && start && !flush;

    // An empty FIFO simply stalls the read
    assign fifo_rd_en = (state == rd_reading) && !fifo_empty && !flush;
    assign last_pop   = fifo_rd_en && (bytes_left == 2'd1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= rd_idle;
            bytes_left <= 2'd0;
            complete   <= 1'b0;
        end else begin
            complete <= 1'b0;
            if (flush) begin
                // Abort any read in progress
                state      <= rd_idle;
                bytes_left <= 2'd0;
            end else begin
                case (state)
                    rd_idle: begin
                        if (accept) begin
                            state      <= rd_reading;
                            bytes_left <= is_8bit ? 2'd1 : 2'd2;
                        end
                    end
                    rd_reading: begin
                        if (fifo_rd_en) begin
                            bytes_left <= bytes_left - 2'd1;
                        end
                        if (last_pop) begin
                            state    <= rd_idle;
                            complete <= 1'b1;
                        end
                    end
                    default: begin
                        state <= rd_idle;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wide      <= !is_8bit;
            immediate <= '0;
        end else if (fifo_rd_en) begin
            // Second byte of a 16-bit read goes to the high half
            if (wide && bytes_left == 2'd1) begin
                immediate[15:8] <= fifo_rd_data;
            end else begin
                immediate[7:0] <= fifo_rd_data;
            end
        end
    end

endmodule

/* verilog/prefetch.sv */
// Prefetch unit
// Holds CS:IP, fetches 16-bit words from CS*16+IP over the instruction
// bus and pushes the returned bytes into the prefetch FIFO. A redirect
// flushes the FIFO and drops any response still in flight.
module prefetch (
    input  logic                 clk,
    input  logic                 arst_n,
    input  fetch_pkg::addr16_t   new_cs,
    input  fetch_pkg::addr16_t   new_ip,
    input  logic                 load_new_ip,
    output fetch_pkg::imem_req_t instr_req,
    input  fetch_pkg::imem_rsp_t instr_rsp,
    output logic                 fifo_wr_en,
    output fetch_pkg::byte_t     fifo_wr_data,
    input  logic                 fifo_nearly_full,
    output logic                 flush
);
    import fetch_pkg::*;

    prefetch_state_t state;
    addr16_t         cs;
    addr16_t         ip;
    word_addr_t      fetch_addr;
    byte_t           saved_high;
    logic [19:0]     phys_addr;
    logic            ack;
    logic            start_fetch;

    assign phys_addr = {cs, 4'h0} + {4'h0, ip};
    assign ack       = instr_rsp.ack;

    // Redirect empties the FIFO and aborts the reader in the same cycle
    assign flush = load_new_ip;

    // Launch only with room for a whole word
    assign start_fetch = (state == pf_idle) && !load_new_ip && !fifo_nearly_full;

    // Access stays up while waiting, also for a response being discarded
    assign instr_req.access  = (state == pf_fetch) || (state == pf_discard);
    assign instr_req.address = fetch_addr;

    always_comb begin
        fifo_wr_en   = 1'b0;
        fifo_wr_data = saved_high;
        if (!load_new_ip) begin
            if (state == pf_fetch && ack) begin
                fifo_wr_en = 1'b1;
                // Odd IP skips the low byte of the word
                fifo_wr_data = ip[0] ? instr_rsp.data[15:8] : instr_rsp.data[7:0];
            end else if (state == pf_high_byte) begin
                fifo_wr_en = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= pf_idle;
            cs    <= reset_cs;
            ip    <= reset_ip;
        end else begin
            if (load_new_ip) begin
                cs <= new_cs;
                ip <= new_ip;
            end

            case (state)
                pf_idle: begin
                    if (start_fetch) begin
                        state <= pf_fetch;
                    end
                end
                pf_fetch: begin
                    if (load_new_ip) begin
                        // Old address superseded, wait out its ack
                        state <= ack ? pf_idle : pf_discard;
                    end else if (ack) begin
                        if (ip[0]) begin
                            ip    <= ip + 16'd1;
                            state <= pf_idle;
                        end else begin
                            state <= pf_high_byte;
                        end
                    end
                end
                pf_high_byte: begin
                    if (!load_new_ip) begin
                        ip <= ip + 16'd2;
                    end
                    state <= pf_idle;
                end
                pf_discard: begin
                    if (ack) begin
                        state <= pf_idle;
                    end
                end
                default: begin
                    state <= pf_idle;
                end
            endcase
        end
    end

    // Address latched at launch so a redirect cannot move it mid-access
    always_ff @(posedge clk) begin
        if (start_fetch) begin
            fetch_addr <= phys_addr[19:1];
        end
        if (state == pf_fetch && ack) begin
            saved_high <= instr_rsp.data[15:8];
        end
    end

endmodule
